// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Bytes in one memory word
  localparam int BYTES_PER_WORD = 4;

  // Width of a processor-side byte address
  localparam int BYTE_ADDR_BITS = 32;

  // Default RAM depths as log2 of the word count
  localparam int DEFAULT_DATA_WORDS_LOG2  = 10;
  localparam int DEFAULT_INSTR_WORDS_LOG2 = 10;

  // One data word
  typedef logic [8*BYTES_PER_WORD-1:0] word_t;

  // One enable bit per byte lane
  typedef logic [BYTES_PER_WORD-1:0] be_t;

  // Byte address as issued by the processor side
  typedef logic [BYTE_ADDR_BITS-1:0] byte_addr_t;

  // Request content that travels with a req strobe.
  // Loader ports reuse it with a word address in the low bits.
  typedef struct packed {
    byte_addr_t addr;
    logic       we;
    be_t        be;
    word_t      wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: region_pkg.sv
`default_nettype none

package region_pkg;

  // Upper address bits that identify the region
  typedef logic [11:0] tag_t;

  // Tag of the local data RAM
  localparam tag_t LOCAL_TAG = 12'h001;

  // Bit where the tag starts in a byte address
  localparam int TAG_LSB = 20;

  // Side that will deliver the next load/store response
  typedef enum logic {
    RESP_RAM,
    RESP_BUS
  } resp_src_t;

endpackage

`default_nettype wire

// File: sp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sp_ram #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  clk,
  input  logic                  en_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic                  we_i,
  input  mem_pkg::be_t          be_i,
  input  mem_pkg::word_t        wdata_i,
  output mem_pkg::word_t        rdata_o
);

  import mem_pkg::*;

  localparam int NUM_WORDS = 2**ADDR_WIDTH;

  word_t mem [NUM_WORDS];

  // Byte-lane writes, old word is read out on a write cycle
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < BYTES_PER_WORD; i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

  // An enabled access needs a known address
  a_addr_known : assert property (
    @(posedge clk) en_i |-> !$isunknown(addr_i)
  ) else $error("sp_ram: unknown address while enabled");

endmodule

`default_nettype wire

// File: ram_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module ram_arbiter #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Loader side, always served
  input  logic                  load_req_i,
  input  mem_pkg::mem_req_t     load_pkt_i,
  output mem_pkg::word_t        load_rdata_o,

  // Processor side, byte addressed
  input  logic                  proc_req_i,
  input  mem_pkg::mem_req_t     proc_pkt_i,
  output logic                  proc_gnt_o,
  output logic                  proc_rvalid_o,
  output mem_pkg::word_t        proc_rdata_o,

  // Shared RAM
  output logic                  ram_en_o,
  output logic [ADDR_WIDTH-1:0] ram_addr_o,
  output logic                  ram_we_o,
  output mem_pkg::be_t          ram_be_o,
  output mem_pkg::word_t        ram_wdata_o,
  input  mem_pkg::word_t        ram_rdata_i
);

  import mem_pkg::*;

  // Byte offset bits dropped from a processor address
  localparam int WORD_OFFSET = $clog2(BYTES_PER_WORD);

  logic proc_rvalid_q;

  // Loader wins, processor waits and keeps its request
  assign proc_gnt_o = proc_req_i & ~load_req_i;
  assign ram_en_o   = load_req_i | proc_gnt_o;

  always_comb
  begin
    if (load_req_i)
    begin
      ram_addr_o  = load_pkt_i.addr[ADDR_WIDTH-1:0];
      ram_we_o    = load_pkt_i.we;
      ram_be_o    = load_pkt_i.be;
      ram_wdata_o = load_pkt_i.wdata;
    end
    else
    begin
      ram_addr_o  = proc_pkt_i.addr[WORD_OFFSET +: ADDR_WIDTH];
      ram_we_o    = proc_pkt_i.we;
      ram_be_o    = proc_pkt_i.be;
      ram_wdata_o = proc_pkt_i.wdata;
    end
  end

  // RAM read is registered, so rvalid trails the grant by one cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      proc_rvalid_q <= 1'b0;
    end
    else
    begin
      proc_rvalid_q <= proc_gnt_o;
    end
  end

  assign proc_rvalid_o = proc_rvalid_q;

  // Both sides see the RAM word, each knows when it is meant for it
  assign load_rdata_o = ram_rdata_i;
  assign proc_rdata_o = ram_rdata_i;

  // A held-off processor request stays up until it is granted
  a_proc_req_held : assert property (
    @(posedge clk) disable iff (!rst_n) proc_req_i && !proc_gnt_o |=> proc_req_i
  ) else $error("ram_arbiter: processor request dropped before its grant");

endmodule

`default_nettype wire

// File: lsu_router.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_router (
  input  logic              clk,
  input  logic              rst_n,

  // Load/store port
  input  logic              lsu_req_i,
  input  mem_pkg::mem_req_t lsu_pkt_i,
  output logic              lsu_gnt_o,
  output logic              lsu_rvalid_o,
  output mem_pkg::word_t    lsu_rdata_o,

  // Local data RAM side
  output logic              ram_req_o,
  input  logic              ram_gnt_i,
  input  logic              ram_rvalid_i,
  input  mem_pkg::word_t    ram_rdata_i,

  // External bus side
  output logic              bus_req_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  mem_pkg::word_t    bus_rdata_i
);

  import region_pkg::*;

  tag_t      req_tag;
  logic      is_local;
  logic      ram_granted;
  logic      bus_granted;
  resp_src_t resp_src_q;
  resp_src_t resp_src_d;

  // Region decode on the upper address bits
  assign req_tag  = lsu_pkt_i.addr[TAG_LSB +: $bits(tag_t)];
  assign is_local = (req_tag == LOCAL_TAG);

  assign ram_req_o = lsu_req_i & is_local;
  assign bus_req_o = lsu_req_i & ~is_local;

  assign ram_granted = ram_req_o & ram_gnt_i;
  assign bus_granted = bus_req_o & bus_gnt_i;

  assign lsu_gnt_o = ram_granted | bus_granted;

  // Remember where the pending response comes from, only on a grant
  always_comb
  begin
    resp_src_d = resp_src_q;
    if (bus_granted)
    begin
      resp_src_d = RESP_BUS;
    end
    else if (ram_granted)
    begin
      resp_src_d = RESP_RAM;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      resp_src_q <= RESP_RAM;
    end
    else
    begin
      resp_src_q <= resp_src_d;
    end
  end

  // Response back to the load/store port
  assign lsu_rdata_o  = (resp_src_q == RESP_BUS) ? bus_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ram_rvalid_i | bus_rvalid_i;

  // One outstanding grant means the two sides never answer together
  a_single_resp : assert property (
    @(posedge clk) disable iff (!rst_n) !(ram_rvalid_i && bus_rvalid_i)
  ) else $error("lsu_router: RAM and bus responses in the same cycle");

endmodule

`default_nettype wire

// File: core_region.sv
`timescale 1ns/100ps
`default_nettype none

module core_region #(
  parameter int DATA_AW  = mem_pkg::DEFAULT_DATA_WORDS_LOG2,
  parameter int INSTR_AW = mem_pkg::DEFAULT_INSTR_WORDS_LOG2
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Load/store port
  input  logic                   lsu_req_i,
  input  mem_pkg::mem_req_t      lsu_pkt_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  output mem_pkg::word_t         lsu_rdata_o,

  // External bus port
  output logic                   bus_req_o,
  output mem_pkg::mem_req_t      bus_pkt_o,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  mem_pkg::word_t         bus_rdata_i,

  // Instruction fetch port
  input  logic                   fetch_req_i,
  input  mem_pkg::byte_addr_t    fetch_addr_i,
  output logic                   fetch_gnt_o,
  output logic                   fetch_rvalid_o,
  output mem_pkg::word_t         fetch_rdata_o,

  // Loader ports
  input  logic                   dload_req_i,
  input  mem_pkg::mem_req_t      dload_pkt_i,
  output mem_pkg::word_t         dload_rdata_o,
  input  logic                   iload_req_i,
  input  mem_pkg::mem_req_t      iload_pkt_i,
  output mem_pkg::word_t         iload_rdata_o
);

  import mem_pkg::*;

  // Router to data arbiter
  logic                data_req;
  logic                data_gnt;
  logic                data_rvalid;
  word_t               data_rdata;

  // Data arbiter to data RAM
  logic                data_mem_en;
  logic [DATA_AW-1:0]  data_mem_addr;
  logic                data_mem_we;
  be_t                 data_mem_be;
  word_t               data_mem_wdata;
  word_t               data_mem_rdata;

  // Instruction arbiter to instruction RAM
  logic                instr_mem_en;
  logic [INSTR_AW-1:0] instr_mem_addr;
  logic                instr_mem_we;
  be_t                 instr_mem_be;
  word_t               instr_mem_wdata;
  word_t               instr_mem_rdata;

  // Same packet goes to the RAM side and out on the bus
  assign bus_pkt_o = lsu_pkt_i;

  lsu_router lsu_router_i (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .lsu_req_i    ( lsu_req_i    ),
    .lsu_pkt_i    ( lsu_pkt_i    ),
    .lsu_gnt_o    ( lsu_gnt_o    ),
    .lsu_rvalid_o ( lsu_rvalid_o ),
    .lsu_rdata_o  ( lsu_rdata_o  ),
    .ram_req_o    ( data_req     ),
    .ram_gnt_i    ( data_gnt     ),
    .ram_rvalid_i ( data_rvalid  ),
    .ram_rdata_i  ( data_rdata   ),
    .bus_req_o    ( bus_req_o    ),
    .bus_gnt_i    ( bus_gnt_i    ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .bus_rdata_i  ( bus_rdata_i  )
  );

  ram_arbiter #(
    .ADDR_WIDTH ( DATA_AW )
  ) data_arbiter_i (
    .clk           ( clk            ),
    .rst_n         ( rst_n          ),
    .load_req_i    ( dload_req_i    ),
    .load_pkt_i    ( dload_pkt_i    ),
    .load_rdata_o  ( dload_rdata_o  ),
    .proc_req_i    ( data_req       ),
    .proc_pkt_i    ( lsu_pkt_i      ),
    .proc_gnt_o    ( data_gnt       ),
    .proc_rvalid_o ( data_rvalid    ),
    .proc_rdata_o  ( data_rdata     ),
    .ram_en_o      ( data_mem_en    ),
    .ram_addr_o    ( data_mem_addr  ),
    .ram_we_o      ( data_mem_we    ),
    .ram_be_o      ( data_mem_be    ),
    .ram_wdata_o   ( data_mem_wdata ),
    .ram_rdata_i   ( data_mem_rdata )
  );

  sp_ram #(
    .ADDR_WIDTH ( DATA_AW )
  ) data_mem_i (
    .clk     ( clk            ),
    .en_i    ( data_mem_en    ),
    .addr_i  ( data_mem_addr  ),
    .we_i    ( data_mem_we    ),
    .be_i    ( data_mem_be    ),
    .wdata_i ( data_mem_wdata ),
    .rdata_o ( data_mem_rdata )
  );

  // Fetch is a full-word read only
  ram_arbiter #(
    .ADDR_WIDTH ( INSTR_AW )
  ) instr_arbiter_i (
    .clk           ( clk             ),
    .rst_n         ( rst_n           ),
    .load_req_i    ( iload_req_i     ),
    .load_pkt_i    ( iload_pkt_i     ),
    .load_rdata_o  ( iload_rdata_o   ),
    .proc_req_i    ( fetch_req_i     ),
    .proc_pkt_i    ( mem_req_t'{addr: fetch_addr_i, we: 1'b0, be: '1, wdata: '0} ),
    .proc_gnt_o    ( fetch_gnt_o     ),
    .proc_rvalid_o ( fetch_rvalid_o  ),
    .proc_rdata_o  ( fetch_rdata_o   ),
    .ram_en_o      ( instr_mem_en    ),
    .ram_addr_o    ( instr_mem_addr  ),
    .ram_we_o      ( instr_mem_we    ),
    .ram_be_o      ( instr_mem_be    ),
    .ram_wdata_o   ( instr_mem_wdata ),
    .ram_rdata_i   ( instr_mem_rdata )
  );

  sp_ram #(
    .ADDR_WIDTH ( INSTR_AW )
  ) instr_mem_i (
    .clk     ( clk             ),
    .en_i    ( instr_mem_en    ),
    .addr_i  ( instr_mem_addr  ),
    .we_i    ( instr_mem_we    ),
    .be_i    ( instr_mem_be    ),
    .wdata_i ( instr_mem_wdata ),
    .rdata_o ( instr_mem_rdata )
  );

endmodule

`default_nettype wire

// File: tb_core_region.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_region;

  import mem_pkg::*;
  import region_pkg::*;

  localparam int DATA_AW      = DEFAULT_DATA_WORDS_LOG2;
  localparam int INSTR_AW     = DEFAULT_INSTR_WORDS_LOG2;
  localparam int CLK_PERIOD   = 20;
  localparam int SETTLE       = CLK_PERIOD / 4;
  localparam int MAX_WAIT     = 16;
  localparam int BUS_AW       = 8;
  localparam int N_WORDS      = 8;
  localparam int LOCAL_CYCLES = 4;
  localparam int BUS_CYCLES   = 12;
  // Loader, local, bus, priority and fetch tests, each access at its worst length
  localparam int TEST_CYCLES  = 3 * N_WORDS + (N_WORDS + 8) * LOCAL_CYCLES
                              + (8 + N_WORDS) * BUS_CYCLES + N_WORDS * LOCAL_CYCLES
                              + 6 * N_WORDS + 20;
  localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  logic       lsu_req_i, lsu_gnt_o, lsu_rvalid_o;
  mem_req_t   lsu_pkt_i;
  word_t      lsu_rdata_o;
  logic       bus_req_o, bus_gnt_i, bus_rvalid_i;
  mem_req_t   bus_pkt_o;
  word_t      bus_rdata_i;
  logic       fetch_req_i, fetch_gnt_o, fetch_rvalid_o;
  byte_addr_t fetch_addr_i;
  word_t      fetch_rdata_o;
  logic       dload_req_i, iload_req_i;
  mem_req_t   dload_pkt_i, iload_pkt_i;
  word_t      dload_rdata_o, iload_rdata_o;

  // Expected RAM contents and the external bus target
  word_t       exp_dmem [2**DATA_AW];
  word_t       exp_imem [2**INSTR_AW];
  word_t       bus_mem [2**BUS_AW];
  logic [31:0] lfsr_q = 32'h44fe;

  core_region #(.DATA_AW(DATA_AW), .INSTR_AW(INSTR_AW)) core_region_i (.*);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t w;
    w = old_w;
    for (int i = 0; i < BYTES_PER_WORD; i++)
    begin
      if (be[i])
      begin
        w[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return w;
  endfunction

  function automatic byte_addr_t local_addr(input int idx);
    return {LOCAL_TAG, {(TAG_LSB - DATA_AW - 2){1'b0}}, DATA_AW'(idx), 2'b00};
  endfunction

  // Any tag but the local one, word index bits as for a local access
  function automatic byte_addr_t bus_addr(input int idx);
    tag_t        tag;
    logic [31:0] mid;
    tag = tag_t'(take_bits(12));
    mid = take_bits(TAG_LSB - DATA_AW - 2);
    if (tag == LOCAL_TAG)
    begin
      tag = ~LOCAL_TAG;
    end
    return {tag, mid[TAG_LSB-DATA_AW-3:0], DATA_AW'(idx), 2'b00};
  endfunction

  function automatic mem_req_t read_pkt(input byte_addr_t addr);
    return mem_req_t'{addr: addr, we: 1'b0, be: '1, wdata: '0};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pkt(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("Watchdog timeout, the tests did not finish in time");
  end

  // External bus target: samples on the rising edge, drives on the falling edge
  initial
  begin : bus_model
    mem_req_t          req;
    logic [BUS_AW-1:0] slot;
    logic              was_req;
    logic              was_gnt;
    logic              busy;
    logic              pending;
    int                gnt_wait;
    int                resp_wait;
    word_t             resp_word;
    busy         = 1'b0;
    pending      = 1'b0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    for (int i = 0; i < 2**BUS_AW; i++)
    begin
      bus_mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'hc3};
    end
    forever
    begin
      @(posedge clk);
      was_req = bus_req_o;
      was_gnt = bus_gnt_i;
      req     = bus_pkt_o;
      slot    = req.addr[BUS_AW+1:2];
      if (was_req && was_gnt)
      begin
        busy      = 1'b1;
        pending   = 1'b0;
        resp_wait = 1 + int'(take_bits(2)) % 3;
        if (req.we)
        begin
          bus_mem[slot] = merge_bytes(bus_mem[slot], req.wdata, req.be);
        end
        resp_word = bus_mem[slot];
      end
      else if (was_req && !busy && !pending)
      begin
        pending  = 1'b1;
        gnt_wait = int'(take_bits(2));
      end
      @(negedge clk);
      bus_gnt_i    = 1'b0;
      bus_rvalid_i = 1'b0;
      if (busy)
      begin
        resp_wait--;
        if (resp_wait == 0)
        begin
          bus_rvalid_i = 1'b1;
          bus_rdata_i  = resp_word;
          busy         = 1'b0;
        end
      end
      else if (pending)
      begin
        if (gnt_wait == 0)
        begin
          bus_gnt_i = 1'b1;
        end
        else
        begin
          gnt_wait--;
        end
      end
    end
  end

  // One load/store transfer, request held until granted; exp_wait < 0 skips the grant timing
  task automatic lsu_access(input mem_req_t pkt, input int exp_wait, output word_t rdata);
    logic to_bus;
    int   gnt_wait;
    int   resp_wait;
    to_bus    = (pkt.addr[TAG_LSB +: $bits(tag_t)] != LOCAL_TAG);
    gnt_wait  = 0;
    resp_wait = 0;
    @(negedge clk);
    lsu_req_i = 1'b1;
    lsu_pkt_i = pkt;
    #(SETTLE);
    while (!lsu_gnt_o)
    begin
      check_bit("bus_req_o", bus_req_o, to_bus);
      gnt_wait++;
      if (gnt_wait > MAX_WAIT)
      begin
        abort_run("No grant on the load/store port");
      end
      @(negedge clk);
      #(SETTLE);
    end
    check_bit("bus_req_o", bus_req_o, to_bus);
    if (to_bus)
    begin
      check_pkt("bus_pkt_o", bus_pkt_o, pkt);
    end
    if (exp_wait >= 0 && gnt_wait != exp_wait)
    begin
      abort_run($sformatf("Load/store grant after %0d cycles, expected %0d", gnt_wait, exp_wait));
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    lsu_pkt_i = '0;
    #(SETTLE);
    // Local responses come exactly one cycle after the grant
    if (!to_bus)
    begin
      check_bit("lsu_rvalid_o", lsu_rvalid_o, 1'b1);
    end
    while (!lsu_rvalid_o)
    begin
      resp_wait++;
      if (resp_wait > MAX_WAIT)
      begin
        abort_run("No response on the load/store port");
      end
      @(negedge clk);
      #(SETTLE);
    end
    rdata = lsu_rdata_o;
  endtask

  task automatic fetch_word(input int idx, input int exp_wait, output word_t rdata);
    int gnt_wait;
    gnt_wait = 0;
    @(negedge clk);
    fetch_req_i  = 1'b1;
    fetch_addr_i = byte_addr_t'(idx) << 2;
    #(SETTLE);
    while (!fetch_gnt_o)
    begin
      gnt_wait++;
      if (gnt_wait > MAX_WAIT)
      begin
        abort_run("No grant on the fetch port");
      end
      @(negedge clk);
      #(SETTLE);
    end
    if (gnt_wait != exp_wait)
    begin
      abort_run($sformatf("Fetch grant after %0d cycles, expected %0d", gnt_wait, exp_wait));
    end
    @(negedge clk);
    fetch_req_i = 1'b0;
    #(SETTLE);
    check_bit("fetch_rvalid_o", fetch_rvalid_o, 1'b1);
    rdata = fetch_rdata_o;
  endtask

  // Loader writes on back-to-back cycles, request stays high throughout
  task automatic load_burst(input logic to_instr, input int first, input int count);
    mem_req_t pkt;
    for (int k = 0; k < count; k++)
    begin
      @(negedge clk);
      pkt = mem_req_t'{addr: byte_addr_t'(first + k), we: 1'b1, be: '1, wdata: take_bits(32)};
      if (to_instr)
      begin
        iload_req_i = 1'b1;
        iload_pkt_i = pkt;
        exp_imem[first + k] = pkt.wdata;
      end
      else
      begin
        dload_req_i = 1'b1;
        dload_pkt_i = pkt;
        exp_dmem[first + k] = pkt.wdata;
      end
    end
    @(negedge clk);
    iload_req_i = 1'b0;
    dload_req_i = 1'b0;
  endtask

  // Single loader read, data is taken one cycle after the request
  task automatic loader_read(input logic to_instr, input int idx, output word_t rdata);
    mem_req_t pkt;
    pkt = mem_req_t'{addr: byte_addr_t'(idx), we: 1'b0, be: '0, wdata: '0};
    @(negedge clk);
    if (to_instr)
    begin
      iload_req_i = 1'b1;
      iload_pkt_i = pkt;
    end
    else
    begin
      dload_req_i = 1'b1;
      dload_pkt_i = pkt;
    end
    @(negedge clk);
    iload_req_i = 1'b0;
    dload_req_i = 1'b0;
    #(SETTLE);
    rdata = to_instr ? iload_rdata_o : dload_rdata_o;
  endtask

  task automatic reset_values();
    #(SETTLE);
    check_bit("lsu_gnt_o", lsu_gnt_o, 1'b0);
    check_bit("lsu_rvalid_o", lsu_rvalid_o, 1'b0);
    check_bit("fetch_gnt_o", fetch_gnt_o, 1'b0);
    check_bit("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
    check_bit("bus_req_o", bus_req_o, 1'b0);
  endtask

  task automatic data_loader_roundtrip();
    word_t got;
    load_burst(1'b0, 0, N_WORDS);
    for (int i = 0; i < N_WORDS; i++)
    begin
      loader_read(1'b0, i, got);
      check_word("dload_rdata_o", got, exp_dmem[i]);
    end
  endtask

  task automatic local_load_store();
    word_t got;
    word_t w;
    be_t   be;
    for (int i = 0; i < N_WORDS; i++)
    begin
      lsu_access(read_pkt(local_addr(i)), 0, got);
      check_word("lsu_rdata_o", got, exp_dmem[i]);
    end
    // Partial writes keep the bytes that are not enabled
    for (int i = 0; i < 4; i++)
    begin
      w  = take_bits(32);
      be = be_t'(take_bits(BYTES_PER_WORD));
      lsu_access(mem_req_t'{addr: local_addr(i), we: 1'b1, be: be, wdata: w}, 0, got);
      exp_dmem[i] = merge_bytes(exp_dmem[i], w, be);
      lsu_access(read_pkt(local_addr(i)), 0, got);
      check_word("lsu_rdata_o", got, exp_dmem[i]);
    end
  endtask

  task automatic bus_routing();
    word_t      got;
    word_t      w;
    byte_addr_t addr;
    // Same word index bits as loaded local words, RAM must stay unchanged
    for (int i = 0; i < 4; i++)
    begin
      addr = bus_addr(i);
      w    = take_bits(32);
      lsu_access(mem_req_t'{addr: addr, we: 1'b1, be: '1, wdata: w}, -1, got);
      lsu_access(read_pkt(addr), -1, got);
      check_word("lsu_rdata_o", got, w);
    end
    for (int i = 0; i < N_WORDS; i++)
    begin
      lsu_access(read_pkt(local_addr(i)), 0, got);
      check_word("lsu_rdata_o", got, exp_dmem[i]);
      lsu_access(read_pkt(bus_addr(i + 16)), -1, got);
      check_word("lsu_rdata_o", got, bus_mem[i + 16]);
    end
  endtask

  task automatic loader_priority();
    word_t got;
    fork
      load_burst(1'b0, 20, 3);
      lsu_access(read_pkt(local_addr(21)), 3, got);
    join
    check_word("lsu_rdata_o", got, exp_dmem[21]);
  endtask

  task automatic instruction_fetch();
    word_t got;
    load_burst(1'b1, 0, N_WORDS);
    for (int i = 0; i < N_WORDS; i++)
    begin
      loader_read(1'b1, i, got);
      check_word("iload_rdata_o", got, exp_imem[i]);
    end
    for (int i = 0; i < N_WORDS; i++)
    begin
      fetch_word(i, 0, got);
      check_word("fetch_rdata_o", got, exp_imem[i]);
    end
    fork
      load_burst(1'b1, N_WORDS, 2);
      fetch_word(N_WORDS + 1, 2, got);
    join
    check_word("fetch_rdata_o", got, exp_imem[N_WORDS + 1]);
  endtask

  initial
  begin
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_pkt_i    = '0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    dload_req_i  = 1'b0;
    dload_pkt_i  = '0;
    iload_req_i  = 1'b0;
    iload_pkt_i  = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    data_loader_roundtrip();
    local_load_store();
    bus_routing();
    loader_priority();
    instruction_fetch();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: core_region.f
mem_pkg.sv
region_pkg.sv
sp_ram.sv
ram_arbiter.sv
lsu_router.sv
core_region.sv
tb_core_region.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_core_region \
  -f core_region.f -o tb_core_region > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_core_region > "$LOG" 2>&1

grep -q "TESTBENCH FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "TESTBENCH PASSED" "$LOG" || { echo "No pass result in $LOG"; exit 1; }
echo "Simulation passed"
